/* Bender.yml */
package:
  name: cadr_alu

sources:
  - files:
      - src/cadr_ir_pkg.sv
      - src/alu_pkg.sv
      - src/alu_slice.sv
      - src/carry_lookahead.sv
      - src/alu_control.sv
      - src/alu_datapath.sv
      - src/q_register.sv
      - src/output_bus.sv
      - src/cadr_alu_top.sv
  - target: test
    files:
      - verification/alu_checker.sv
      - verification/tb_cadr_alu.sv

/* build.f */
src/cadr_ir_pkg.sv
src/alu_pkg.sv
src/alu_slice.sv
src/carry_lookahead.sv
src/alu_control.sv
src/alu_datapath.sv
src/q_register.sv
src/output_bus.sv
src/cadr_alu_top.sv
verification/alu_checker.sv
verification/tb_cadr_alu.sv

/* src/alu_control.sv */
// ALU carry and function control
`default_nettype none

module alu_control (
   input  wire cadr_ir_pkg::ir_word_t ir,
   input  wire        a31,
   input  wire        q0,
   output logic [3:0] aluf,
   output logic       alumode,
   output logic       cin0,
   output logic [1:0] osel,
   output logic [1:0] q_ctl
);

   logic [5:0] fn;
   logic       iralu;
   logic       irjump;
   logic       special;
   logic       mul;
   logic       div;
   logic       divposlasttime;
   logic       divsubcond;
   logic       divaddcond;
   logic       mulnop;
   logic       aluadd;
   logic       alusub;

   // ******************************
   // Operation decode
   // ******************************

   assign fn      = ir.alu.alu_fn;
   assign iralu   = (ir.alu.op == cadr_ir_pkg::op_alu);
   assign irjump  = (ir.jump.op == cadr_ir_pkg::op_jump);
   assign special = iralu & fn[alu_pkg::fn_special_bit];
   assign mul     = special & (fn[1:0] == alu_pkg::fn_mul_step);
   assign div     = special & (fn[1:0] == alu_pkg::fn_div_step);

   // Sign of the last partial remainder.
   assign divposlasttime = q0 | fn[alu_pkg::fn_div_first_bit];
   assign divsubcond     = div & divposlasttime;
   assign divaddcond     = div & (fn[alu_pkg::fn_div_corr_bit] | ~divposlasttime);
   assign mulnop         = mul & ~q0;

   assign aluadd = (divaddcond & ~a31) | (divsubcond & a31) | mul;
   assign alusub = mulnop | (divsubcond & ~a31) | (divaddcond & a31) | irjump;

   // ******************************
   // Function select
   // ******************************

   always_comb begin
      case ({alusub, aluadd})
         2'b00: begin
            aluf    = {fn[0], fn[1], ~fn[3], ~fn[2]};
            alumode = ~fn[4];                     // IR 7.
            cin0    = ir.alu.cin;
         end
         2'b01: begin
            aluf    = alu_pkg::aluf_add;
            alumode = 1'b0;
            cin0    = 1'b0;
         end
         2'b10: begin
            aluf    = alu_pkg::aluf_sub;
            alumode = 1'b0;
            cin0    = 1'b1;                       // True A minus M.
         end
         default: begin
            aluf    = alu_pkg::aluf_both;         // Multiply step with q0 clear.
            alumode = 1'b1;
            cin0    = 1'b1;
         end
      endcase
   end

   assign osel  = ir.alu.osel & {2{iralu}};
   assign q_ctl = ir.alu.q_ctl & {2{iralu}};

endmodule

`default_nettype wire

/* src/alu_datapath.sv */
// 32 bit ALU datapath
`default_nettype none

module alu_datapath (
   input  wire  [alu_pkg::alu_width-1:0] a,
   input  wire  [alu_pkg::alu_width-1:0] b,
   input  wire  [3:0]                    aluf,
   input  wire                           alumode,
   input  wire                           cin0,
   output logic [alu_pkg::alu_width-1:0] f,
   output logic                          cout32
);

   wire [7:0] x;
   wire [7:0] y;
   wire [7:0] cin_n;    // Active low carry into each slice.
   wire       xx0;
   wire       yy0;
   wire       xx1;
   wire       yy1;
   wire       cin32_n;

   assign cin_n[0] = ~cin0;

   // ******************************
   // Function slices
   // ******************************

   for (genvar i = 0; i < 8; i++) begin : g_slice
      alu_slice slice_i (
         .a     (a[4*i +: 4]),
         .b     (b[4*i +: 4]),
         .s     (aluf),
         .mode  (alumode),
         .cin_n (cin_n[i]),
         .f     (f[4*i +: 4]),
         .x     (x[i]),
         .y     (y[i])
      );
   end

   // ******************************
   // Carry tree
   // ******************************

   carry_lookahead lo_cla_i (
      .x(x[3:0]), .y(y[3:0]), .cin_n(cin_n[0]),
      .cout0_n(cin_n[1]), .cout1_n(cin_n[2]), .cout2_n(cin_n[3]),
      .xout(xx0), .yout(yy0)
   );

   carry_lookahead hi_cla_i (
      .x(x[7:4]), .y(y[7:4]), .cin_n(cin_n[4]),
      .cout0_n(cin_n[5]), .cout1_n(cin_n[6]), .cout2_n(cin_n[7]),
      .xout(xx1), .yout(yy1)
   );

   // Second level joins the two halves, upper groups held inactive.
   carry_lookahead top_cla_i (
      .x({2'b11, xx1, xx0}), .y({2'b11, yy1, yy0}), .cin_n(cin_n[0]),
      .cout0_n(cin_n[4]), .cout1_n(cin32_n), .cout2_n(),
      .xout(), .yout()
   );

   assign cout32 = ~cin32_n;

endmodule

`default_nettype wire

/* src/alu_pkg.sv */
// ALU function and select codes
`default_nettype none

package alu_pkg;

   localparam int alu_width = 32;

   // Special functions have alu_fn[5] (IR 8) set.
   localparam int         fn_special_bit   = 5;
   localparam logic [1:0] fn_mul_step      = 2'b00;  // IR 4..3.
   localparam logic [1:0] fn_div_step      = 2'b01;  // IR 4..3.
   localparam int         fn_div_first_bit = 3;      // IR 6, first divide step.
   localparam int         fn_div_corr_bit  = 2;      // IR 5, remainder correction.

   // Forced slice codes.
   localparam logic [3:0] aluf_add  = 4'b1001;  // Mode 0.
   localparam logic [3:0] aluf_sub  = 4'b0110;  // Mode 0.
   localparam logic [3:0] aluf_both = 4'b1111;  // Mode 1, passes A.

   // Q register control.
   localparam logic [1:0] q_none  = 2'b00;
   localparam logic [1:0] q_left  = 2'b01;
   localparam logic [1:0] q_right = 2'b10;
   localparam logic [1:0] q_load  = 2'b11;

   // Output bus select.
   localparam logic [1:0] osel_alu   = 2'b00;
   localparam logic [1:0] osel_alu_b = 2'b01;
   localparam logic [1:0] osel_right = 2'b10;
   localparam logic [1:0] osel_left  = 2'b11;

endpackage

`default_nettype wire

/* src/alu_slice.sv */
// Four bit ALU slice
`default_nettype none

module alu_slice (
   input  wire  [3:0] a,
   input  wire  [3:0] b,
   input  wire  [3:0] s,
   input  wire        mode,
   input  wire        cin_n,
   output logic [3:0] f,
   output logic       x,
   output logic       y
);

   logic [3:0] p;      // Inverted propagate terms.
   logic [3:0] g;      // Inverted generate terms.
   logic [3:0] prop;
   logic [3:0] gen;
   logic [3:0] c;      // Ripple carry into each bit.

   // ******************************
   // Per bit terms and ripple
   // ******************************

   always_comb begin
      c[0] = ~cin_n;
      for (int i = 0; i < 4; i++) begin
         p[i] = ~(a[i] | (s[0] & b[i]) | (s[1] & ~b[i]));
         g[i] = ~((s[2] & a[i] & ~b[i]) | (s[3] & a[i] & b[i]));
         if (i < 3) begin
            c[i+1] = ~g[i] | (~p[i] & c[i]);
         end
         // Logic mode forces the carry term high.
         f[i] = p[i] ^ g[i] ^ (mode | c[i]);
      end
   end

   assign prop = ~p;
   assign gen  = ~g;

   // ******************************
   // Group lookahead outputs
   // ******************************

   assign x = ~(&prop);     // Active low.
   assign y = ~(gen[3] |
                (prop[3] & gen[2]) |
                (prop[3] & prop[2] & gen[1]) |
                (prop[3] & prop[2] & prop[1] & gen[0]));

endmodule

`default_nettype wire

/* src/cadr_alu_top.sv */
// CADR ALU section
`default_nettype none

module cadr_alu_top (
   input  wire                             clk,
   input  wire                             rst_n,
   input  wire                             exec,
   input  wire  [cadr_ir_pkg::ir_width-1:0] ir,
   input  wire  [alu_pkg::alu_width-1:0]   a,
   input  wire  [alu_pkg::alu_width-1:0]   m,
   output wire  [alu_pkg::alu_width-1:0]   ob,
   output wire                             ob_valid,
   output wire  [alu_pkg::alu_width-1:0]   q,
   output wire                             cout
);

   wire [3:0]                    aluf;
   wire                          alumode;
   wire                          cin0;
   wire [1:0]                    osel;
   wire [1:0]                    q_ctl;
   wire [alu_pkg::alu_width-1:0] alu;
   wire                          cout32;

   // ******************************
   // Control and datapath
   // ******************************

   alu_control control_i (
      .ir      (cadr_ir_pkg::ir_word_t'(ir)),
      .a31     (a[alu_pkg::alu_width-1]),
      .q0      (q[0]),
      .aluf    (aluf),
      .alumode (alumode),
      .cin0    (cin0),
      .osel    (osel),
      .q_ctl   (q_ctl)
   );

   alu_datapath datapath_i (
      .a(a), .b(m), .aluf(aluf), .alumode(alumode), .cin0(cin0),
      .f(alu), .cout32(cout32)
   );

   // ******************************
   // Registers
   // ******************************

   q_register qreg_i (
      .clk(clk), .rst_n(rst_n), .exec(exec), .q_ctl(q_ctl),
      .alu31(alu[alu_pkg::alu_width-1]), .alu0(alu[0]), .alu(alu),
      .q(q)
   );

   output_bus obus_i (
      .clk(clk), .rst_n(rst_n), .exec(exec), .osel(osel), .alu(alu),
      .cout32(cout32), .q31(q[alu_pkg::alu_width-1]),
      .ob(ob), .ob_valid(ob_valid), .cout(cout)
   );

endmodule

`default_nettype wire

/* src/cadr_ir_pkg.sv */
// CADR instruction word
`default_nettype none

package cadr_ir_pkg;

   localparam int ir_width = 49;

   // Major op codes in IR 44..43.
   localparam logic [1:0] op_alu  = 2'b00;
   localparam logic [1:0] op_jump = 2'b01;

   // ******************************
   // ALU instruction view
   // ******************************

   typedef struct packed {
      logic [3:0]  spare_hi;   // IR 48..45.
      logic [1:0]  op;         // IR 44..43.
      logic [28:0] spare_mid;  // IR 42..14.
      logic [1:0]  osel;       // IR 13..12.
      logic [2:0]  spare_lo;   // IR 11..9.
      logic [5:0]  alu_fn;     // IR 8..3.
      logic        cin;        // IR 2.
      logic [1:0]  q_ctl;      // IR 1..0.
   } alu_ir_t;

   // ******************************
   // Jump instruction view
   // ******************************

   // Only op matters here, the branch condition is not decoded.
   typedef struct packed {
      logic [3:0]  spare_hi;   // IR 48..45.
      logic [1:0]  op;         // IR 44..43.
      logic [32:0] spare_mid;  // IR 42..10.
      logic [9:0]  cond;       // IR 9..0.
   } jump_ir_t;

   // Same 49 bits, read as either kind of instruction.
   typedef union packed {
      alu_ir_t  alu;
      jump_ir_t jump;
   } ir_word_t;

endpackage

`default_nettype wire

/* src/carry_lookahead.sv */
// Group carry lookahead
`default_nettype none

module carry_lookahead (
   input  wire  [3:0] x,
   input  wire  [3:0] y,
   input  wire        cin_n,
   output logic       cout0_n,
   output logic       cout1_n,
   output logic       cout2_n,
   output logic       xout,
   output logic       yout
);

   logic [3:0] p;
   logic [3:0] g;
   logic       c0;

   assign p  = ~x;
   assign g  = ~y;
   assign c0 = ~cin_n;

   // Carries into groups 1, 2 and 3.
   assign cout0_n = ~(g[0] | (p[0] & c0));
   assign cout1_n = ~(g[1] | (p[1] & g[0]) | (p[1] & p[0] & c0));
   assign cout2_n = ~(g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) |
                      (p[2] & p[1] & p[0] & c0));

   // Block terms for the next level.
   assign xout = ~(&p);
   assign yout = ~(g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1]) |
                   (p[3] & p[2] & p[1] & g[0]));

endmodule

`default_nettype wire

/* src/output_bus.sv */
// Output bus shifter and register
`default_nettype none

module output_bus (
   input  wire                           clk,
   input  wire                           rst_n,
   input  wire                           exec,
   input  wire  [1:0]                    osel,
   input  wire  [alu_pkg::alu_width-1:0] alu,
   input  wire                           cout32,
   input  wire                           q31,
   output logic [alu_pkg::alu_width-1:0] ob,
   output logic                          ob_valid,
   output logic                          cout
);

   logic [alu_pkg::alu_width-1:0] ob_next;

   always_comb begin
      case (osel)
         alu_pkg::osel_alu,
         alu_pkg::osel_alu_b: ob_next = alu;
         alu_pkg::osel_right: ob_next = {cout32, alu[alu_pkg::alu_width-1:1]};
         alu_pkg::osel_left:  ob_next = {alu[alu_pkg::alu_width-2:0], q31};
         default:             ob_next = alu;
      endcase
   end

   // ******************************
   // Registered output
   // ******************************

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ob       <= '0;
         cout     <= 1'b0;
         ob_valid <= 1'b0;
      end else begin
         ob_valid <= exec;      // One cycle after the strobe.
         if (exec) begin
            ob   <= ob_next;
            cout <= cout32;
         end
      end
   end

endmodule

`default_nettype wire

/* src/q_register.sv */
// Q register
`default_nettype none

module q_register (
   input  wire                           clk,
   input  wire                           rst_n,
   input  wire                           exec,
   input  wire  [1:0]                    q_ctl,
   input  wire                           alu31,
   input  wire                           alu0,
   input  wire  [alu_pkg::alu_width-1:0] alu,
   output logic [alu_pkg::alu_width-1:0] q
);

   // ******************************
   // Multiply and divide shifts
   // ******************************

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         q <= '0;
      end else if (exec) begin
         case (q_ctl)
            alu_pkg::q_left: begin
               // Quotient bit is set when the remainder stayed positive.
               q <= {q[alu_pkg::alu_width-2:0], ~alu31};
            end
            alu_pkg::q_right: begin
               q <= {alu0, q[alu_pkg::alu_width-1:1]};   // Low product bit.
            end
            alu_pkg::q_load: begin
               q <= alu;
            end
            alu_pkg::q_none: begin
               q <= q;
            end
            default: begin
               q <= q;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* verification/alu_checker.sv */
// ALU section checker
`default_nettype none

module alu_checker (
   input  wire                             clk,
   input  wire                             rst_n,
   input  wire                             exec,
   input  wire [cadr_ir_pkg::ir_width-1:0] ir,
   input  wire [alu_pkg::alu_width-1:0]    a,
   input  wire [alu_pkg::alu_width-1:0]    m,
   input  wire [alu_pkg::alu_width-1:0]    ob,
   input  wire                             ob_valid,
   input  wire [alu_pkg::alu_width-1:0]    q,
   input  wire                             cout,
   output int                              checks,
   output int                              value_errors,
   output int                              valid_errors
);

   logic [31:0] model_q;
   logic [31:0] exp_ob;
   logic        exp_cout;
   logic        exp_valid;
   string       exp_name;

   // ******************************
   // Reference model
   // ******************************

   // Bitwise 74181 terms with a plain ripple carry give {carry out, f}.
   function automatic logic [32:0] alu181_ripple(input logic [31:0] x, input logic [31:0] y,
                                                input logic [3:0] s, input logic mode,
                                                input logic cin);
      logic [31:0] f;
      logic        c;
      logic        p;
      logic        g;
      c = cin;
      for (int i = 0; i < 32; i++) begin
         p    = ~(x[i] | (s[0] & y[i]) | (s[1] & ~y[i]));
         g    = ~((s[2] & x[i] & ~y[i]) | (s[3] & x[i] & y[i]));
         f[i] = p ^ g ^ (mode | c);
         c    = ~g | (~p & c);
      end
      return {c, f};
   endfunction

   // Returns {s, mode, cin} for the instruction.
   function automatic logic [5:0] slice_controls(input cadr_ir_pkg::ir_word_t w,
                                                 input logic a31, input logic q0);
      logic [5:0] fn;
      logic       pos;
      fn  = w.alu.alu_fn;
      pos = q0 | fn[alu_pkg::fn_div_first_bit];
      if (w.jump.op == cadr_ir_pkg::op_jump) return {alu_pkg::aluf_sub, 2'b01};
      if (w.alu.op == cadr_ir_pkg::op_alu && fn[alu_pkg::fn_special_bit]) begin
         if (fn[1:0] == alu_pkg::fn_mul_step) begin
            return q0 ? {alu_pkg::aluf_add, 2'b00} : {alu_pkg::aluf_both, 2'b11};
         end
         if (fn[1:0] == alu_pkg::fn_div_step) begin
            if (pos && fn[alu_pkg::fn_div_corr_bit]) return {alu_pkg::aluf_both, 2'b11};
            return (pos == a31) ? {alu_pkg::aluf_add, 2'b00} : {alu_pkg::aluf_sub, 2'b01};
         end
      end
      return {fn[0], fn[1], ~fn[3], ~fn[2], ~fn[4], w.alu.cin};
   endfunction

   always @(posedge clk) begin : model_step
      cadr_ir_pkg::ir_word_t w;
      logic [5:0]            sel;
      logic [32:0]           res;
      logic                  iralu;
      logic [1:0]            osel_eff;
      logic [1:0]            qctl_eff;
      if (!rst_n) begin
         model_q   = '0;
         exp_ob    = '0;
         exp_cout  = 1'b0;
         exp_valid = 1'b0;
         exp_name  = "reset";
      end else begin
         exp_valid = exec;
         if (exec) begin
            w        = ir;
            iralu    = (w.alu.op == cadr_ir_pkg::op_alu);
            osel_eff = iralu ? w.alu.osel : alu_pkg::osel_alu;   // Jumps ignore both fields.
            qctl_eff = iralu ? w.alu.q_ctl : alu_pkg::q_none;
            sel      = slice_controls(w, a[31], model_q[0]);
            res      = alu181_ripple(a, m, sel[5:2], sel[1], sel[0]);
            exp_cout = res[32];
            exp_name = !iralu ? "jump_compare" :
                       w.alu.alu_fn[alu_pkg::fn_special_bit] ? "mul_div_step" :
                       osel_eff[1] ? "out_shift" : "alu_fn";
            case (osel_eff)
               alu_pkg::osel_right: exp_ob = {res[32], res[31:1]};
               alu_pkg::osel_left:  exp_ob = {res[30:0], model_q[31]};
               default:             exp_ob = res[31:0];
            endcase
            case (qctl_eff)
               alu_pkg::q_left:  model_q = {model_q[30:0], ~res[31]};
               alu_pkg::q_right: model_q = {res[0], model_q[31:1]};
               alu_pkg::q_load:  model_q = res[31:0];
               default:          model_q = model_q;
            endcase
         end
      end
   end

   // ******************************
   // Comparison
   // ******************************

   task automatic report_mismatch(input string what, input logic [31:0] expv,
                                  input logic [31:0] actv);
      value_errors++;
      $display("ERROR %s %s expected %h actual %h at %0t", exp_name, what, expv, actv, $time);
   endtask

   // Outputs are compared half a cycle after the edge that loads them.
   always @(negedge clk) begin
      if (!rst_n) begin
         checks       = 0;
         value_errors = 0;
         valid_errors = 0;
      end else begin
         checks++;
         if (ob_valid !== exp_valid) begin
            valid_errors++;
            if (exp_valid) begin
               $display("ob_valid did not pulse in the cycle after an exec cycle at %0t", $time);
            end else begin
               $display("ob_valid was high although the cycle before had no exec at %0t", $time);
            end
         end
         if (ob !== exp_ob) report_mismatch("ob", exp_ob, ob);
         if (cout !== exp_cout) report_mismatch("cout", {31'b0, exp_cout}, {31'b0, cout});
         if (q !== model_q) report_mismatch("q", model_q, q);
      end
   end

endmodule

`default_nettype wire

/* verification/tb_cadr_alu.sv */
// ALU section testbench
`default_nettype none

module tb_cadr_alu;

   localparam int phase_cycles   = 600;
   localparam int num_phases     = 4;
   localparam int timeout_cycles = num_phases * phase_cycles + 64;

   logic                             clk;
   logic                             rst_n;
   logic                             exec;
   logic [cadr_ir_pkg::ir_width-1:0] ir;
   logic [alu_pkg::alu_width-1:0]    a;
   logic [alu_pkg::alu_width-1:0]    m;
   wire  [alu_pkg::alu_width-1:0]    ob;
   wire  [alu_pkg::alu_width-1:0]    q;
   wire                              ob_valid;
   wire                              cout;
   logic [31:0]                      lfsr;
   int                               cycle_count;
   int                               mul_idx;      // Step within the multiply sequence.
   int                               checks;
   int                               value_errors;
   int                               valid_errors;

   cadr_alu_top dut_i (
      .clk(clk), .rst_n(rst_n), .exec(exec), .ir(ir), .a(a), .m(m),
      .ob(ob), .ob_valid(ob_valid), .q(q), .cout(cout)
   );

   alu_checker checker_i (
      .clk(clk), .rst_n(rst_n), .exec(exec), .ir(ir), .a(a), .m(m),
      .ob(ob), .ob_valid(ob_valid), .q(q), .cout(cout),
      .checks(checks), .value_errors(value_errors), .valid_errors(valid_errors)
   );

   always #20 clk = ~clk;

   // Galois LFSR, one step per bit taken.
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r    = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return r;
   endfunction

   function automatic cadr_ir_pkg::ir_word_t make_ir(input int phase);
      cadr_ir_pkg::ir_word_t w;
      logic [31:0]           hi;
      hi = take_bits(17);
      w  = {hi[16:0], take_bits(32)};
      w.alu.op = (phase == 3) ? cadr_ir_pkg::op_jump : cadr_ir_pkg::op_alu;
      case (phase)
         0: w.alu.alu_fn[alu_pkg::fn_special_bit] = 1'b0;
         1: begin
            w.alu.alu_fn[alu_pkg::fn_special_bit] = (mul_idx != 0);
            w.alu.alu_fn[1:0] = alu_pkg::fn_mul_step;
            w.alu.q_ctl = (mul_idx == 0) ? alu_pkg::q_load : alu_pkg::q_right;
         end
         2: begin
            w.alu.alu_fn[alu_pkg::fn_special_bit] = 1'b1;
            w.alu.alu_fn[1:0] = alu_pkg::fn_div_step;   // IR 6 and IR 5 stay random.
            w.alu.q_ctl       = alu_pkg::q_left;
         end
         default: w.alu.op = cadr_ir_pkg::op_jump;
      endcase
      return w;
   endfunction

   task automatic drive_cycle(input int phase);
      logic                  go;
      cadr_ir_pkg::ir_word_t w;
      logic [31:0]           a_next;
      logic [31:0]           m_next;
      go     = (take_bits(2) != 2'b00);   // About three cycles in four.
      w      = make_ir(phase);
      a_next = take_bits(32);
      m_next = take_bits(32);
      if (go && phase == 1) begin
         mul_idx = (mul_idx == 32) ? 0 : mul_idx + 1;
      end
      @(posedge clk);
      exec <= go;
      ir   <= w;
      a    <= a_next;
      m    <= m_next;
   endtask

   // ******************************
   // Test sequence
   // ******************************

   initial begin
      clk         = 1'b0;
      rst_n       = 1'b0;
      exec        = 1'b0;
      ir          = '0;
      a           = '0;
      m           = '0;
      lfsr        = 32'h0ae5_1699;
      cycle_count = 0;
      mul_idx     = 0;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      for (int phase = 0; phase < num_phases; phase++) begin
         for (int n = 0; n < phase_cycles; n++) begin
            drive_cycle(phase);
         end
      end
      @(posedge clk);
      exec <= 1'b0;
      repeat (2) @(posedge clk);
      $display("Checks %0d, value errors %0d, valid errors %0d",
               checks, value_errors, valid_errors);
      if (value_errors == 0 && valid_errors == 0 && checks > 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_cycles) begin
         $display("Timeout after %0d cycles, the test sequence did not complete", cycle_count);
         $display("Done: errors found");
         $finish;
      end
   end

endmodule

`default_nettype wire
